//--- verilog/clock_set_params.svh
`ifndef CLOCK_SET_PARAMS_SVH
`define CLOCK_SET_PARAMS_SVH

// consecutive held cycles before a button pair acts
`define CS_HOLD_CYCLES 3

// editable digits, index 0 is second units
`define CS_NUM_DIGITS 14

// width of the cursor index
`define CS_CURSOR_W 4

// 2023-01-01 00:00:00
// yyyy mm dd hh mm ss, one bcd digit per nibble
`define CS_RESET_DATETIME 56'h2023_0101_00_00_00

`endif

//--- verilog/clock_set_pkg.sv
`default_nettype none

package clock_set_pkg;

    // same 56 bits seen flat or as fourteen bcd digits
    typedef union packed {
        logic [55:0] raw;           // nibble n is cursor digit n
        struct packed {
            logic [3:0] year_th;
            logic [3:0] year_h;
            logic [3:0] year_t;
            logic [3:0] year_u;
            logic [3:0] month_t;
            logic [3:0] month_u;
            logic [3:0] day_t;
            logic [3:0] day_u;
            logic [3:0] hour_t;
            logic [3:0] hour_u;
            logic [3:0] min_t;
            logic [3:0] min_u;
            logic [3:0] sec_t;
            logic [3:0] sec_u;
        } digits;
    } datetime_u;

endpackage

`default_nettype wire

//--- verilog/button_hold.sv
`timescale 1ns/1ps
`default_nettype none

`include "clock_set_params.svh"

module button_hold (
    input  logic clk,
    input  logic arst_n,
    input  logic set_en,
    input  logic first_btn,
    input  logic second_btn,
    output logic first_pulse,
    output logic second_pulse
);

    logic [$clog2(`CS_HOLD_CYCLES + 1) - 1:0] hold_cnt;
    logic                                     held;
    logic                                     fire;

    assign held = set_en && (first_btn || second_btn);

    // count hits the limit on this edge, pulse goes out with it
    assign fire = held && (hold_cnt == ($bits(hold_cnt))'(`CS_HOLD_CYCLES - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hold_cnt <= '0;
        end else if (!held) begin
            hold_cnt <= '0;                 // released or set mode left
        end else if (hold_cnt != ($bits(hold_cnt))'(`CS_HOLD_CYCLES)) begin
            hold_cnt <= hold_cnt + 1'b1;    // saturates at the limit
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            first_pulse  <= 1'b0;
            second_pulse <= 1'b0;
        end else begin
            first_pulse  <= fire && first_btn;  // first button wins
            second_pulse <= fire && !first_btn;
        end
    end

endmodule

`default_nettype wire

//--- verilog/cursor_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "clock_set_params.svh"

module cursor_ctrl (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    left_pulse,
    input  logic                    right_pulse,
    output logic [`CS_CURSOR_W-1:0] cursor
);

    // left moves toward the year digits, right toward the seconds
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cursor <= `CS_CURSOR_W'(`CS_NUM_DIGITS - 1);    // starts on year thousands
        end else if (left_pulse) begin
            if (cursor >= `CS_CURSOR_W'(`CS_NUM_DIGITS - 1)) begin
                cursor <= '0;
            end else begin
                cursor <= cursor + 1'b1;
            end
        end else if (right_pulse) begin
            if (cursor == '0) begin
                cursor <= `CS_CURSOR_W'(`CS_NUM_DIGITS - 1);
            end else begin
                cursor <= cursor - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/digit_editor.sv
`timescale 1ns/1ps
`default_nettype none

`include "clock_set_params.svh"

module digit_editor (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      up_pulse,
    input  logic                      down_pulse,
    input  logic [`CS_CURSOR_W-1:0]   cursor,
    output clock_set_pkg::datetime_u  datetime
);

    clock_set_pkg::datetime_u  dt_q;

    logic [`CS_CURSOR_W+1:0]   bit_pos;
    logic [3:0]                cur_digit;
    logic [3:0]                dig_min;
    logic [3:0]                dig_max;
    logic [3:0]                up_val;
    logic [3:0]                down_val;

    logic [13:0]               year_bin;
    logic [4:0]                month_bin;
    logic                      leap;
    logic                      feb;
    logic                      long_month;
    logic                      year_hi_zero;

    assign bit_pos   = {cursor, 2'b00};
    assign cur_digit = dt_q.raw[bit_pos +: 4];

    assign year_bin = 14'(dt_q.digits.year_th) * 14'd1000
                    + 14'(dt_q.digits.year_h) * 14'd100
                    + 14'(dt_q.digits.year_t) * 14'd10
                    + 14'(dt_q.digits.year_u);

    assign month_bin = 5'(dt_q.digits.month_t) * 5'd10 + 5'(dt_q.digits.month_u);

    assign leap = (year_bin % 14'd400 == 14'd0)
               || ((year_bin % 14'd4 == 14'd0) && (year_bin % 14'd100 != 14'd0));

    assign feb = (month_bin == 5'd2);

    assign long_month = (month_bin == 5'd1) || (month_bin == 5'd3)
                     || (month_bin == 5'd5) || (month_bin == 5'd7)
                     || (month_bin == 5'd8) || (month_bin == 5'd10)
                     || (month_bin == 5'd12);

    // year 0000 is not allowed
    assign year_hi_zero = (dt_q.digits.year_th == 4'd0)
                       && (dt_q.digits.year_h == 4'd0)
                       && (dt_q.digits.year_t == 4'd0);

    // limits of the digit under the cursor
    always_comb begin
        dig_min = 4'd0;
        dig_max = 4'd9;
        case (cursor)
            `CS_CURSOR_W'd1, `CS_CURSOR_W'd3: begin     // second and minute tens
                dig_max = 4'd5;
            end
            `CS_CURSOR_W'd4: begin                      // hour units
                if (dt_q.digits.hour_t == 4'd2) begin
                    dig_max = 4'd3;
                end
            end
            `CS_CURSOR_W'd5: begin                      // hour tens
                dig_max = 4'd2;
            end
            `CS_CURSOR_W'd6: begin                      // day units
                if (dt_q.digits.day_t == 4'd0) begin
                    dig_min = 4'd1;
                end else if (dt_q.digits.day_t == 4'd3) begin
                    dig_max = long_month ? 4'd1 : 4'd0;
                end else if (dt_q.digits.day_t == 4'd2 && feb) begin
                    dig_max = leap ? 4'd9 : 4'd8;
                end
            end
            `CS_CURSOR_W'd7: begin                      // day tens
                dig_max = feb ? 4'd2 : 4'd3;
            end
            `CS_CURSOR_W'd8: begin                      // month units
                if (dt_q.digits.month_t == 4'd1) begin
                    dig_max = 4'd2;
                end else begin
                    dig_min = 4'd1;
                end
            end
            `CS_CURSOR_W'd9: begin                      // month tens
                dig_max = 4'd1;
            end
            `CS_CURSOR_W'd10: begin                     // year units
                if (year_hi_zero) begin
                    dig_min = 4'd1;
                end
            end
            default: begin
                dig_min = 4'd0;
                dig_max = 4'd9;
            end
        endcase
    end

    // wrap at either end of the range
    assign up_val   = (cur_digit >= dig_max) ? dig_min : cur_digit + 4'd1;
    assign down_val = (cur_digit <= dig_min) ? dig_max : cur_digit - 4'd1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dt_q.raw <= `CS_RESET_DATETIME;
        end else if (up_pulse) begin
            dt_q.raw[bit_pos +: 4] <= up_val;
        end else if (down_pulse) begin
            dt_q.raw[bit_pos +: 4] <= down_val;
        end
    end

    assign datetime = dt_q;

endmodule

`default_nettype wire

//--- verilog/weekday_calc.sv
`timescale 1ns/1ps
`default_nettype none

module weekday_calc (
    input  logic                      clk,
    input  logic                      arst_n,
    input  clock_set_pkg::datetime_u  datetime,
    output logic [3:0]                week
);

    logic [13:0] year_bin;
    logic [4:0]  month_bin;
    logic [6:0]  day_bin;
    logic [13:0] y_adj;
    logic [4:0]  m_adj;
    logic [15:0] sum;
    logic [2:0]  w_mod;

    assign year_bin = 14'(datetime.digits.year_th) * 14'd1000
                    + 14'(datetime.digits.year_h) * 14'd100
                    + 14'(datetime.digits.year_t) * 14'd10
                    + 14'(datetime.digits.year_u);

    assign month_bin = 5'(datetime.digits.month_t) * 5'd10 + 5'(datetime.digits.month_u);
    assign day_bin   = 7'(datetime.digits.day_t) * 7'd10 + 7'(datetime.digits.day_u);

    // jan and feb count as months 13 and 14 of the year before
    always_comb begin
        if (month_bin == 5'd1 || month_bin == 5'd2) begin
            m_adj = month_bin + 5'd12;
            y_adj = year_bin - 14'd1;
        end else begin
            m_adj = month_bin;
            y_adj = year_bin;
        end
    end

    // gregorian formula, never negative since y/4 >= y/100
    assign sum = 16'(day_bin)
               + 16'(m_adj) * 16'd2
               + (16'(m_adj) + 16'd1) * 16'd3 / 16'd5
               + 16'(y_adj)
               + 16'(y_adj) / 16'd4
               - 16'(y_adj) / 16'd100
               + 16'(y_adj) / 16'd400
               + 16'd1;

    assign w_mod = 3'(sum % 16'd7);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            week <= 4'd7;                       // reset date is a sunday
        end else if (w_mod == 3'd0) begin
            week <= 4'd7;
        end else begin
            week <= {1'b0, w_mod};
        end
    end

endmodule

`default_nettype wire

//--- verilog/clock_set_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "clock_set_params.svh"

module clock_set_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    set_en,
    input  logic                    btn_left,
    input  logic                    btn_right,
    input  logic                    btn_up,
    input  logic                    btn_down,
    output logic [15:0]             year,
    output logic [7:0]              month,
    output logic [7:0]              day,
    output logic [7:0]              hour,
    output logic [7:0]              minute,
    output logic [7:0]              second,
    output logic [3:0]              week,
    output logic [`CS_CURSOR_W-1:0] cursor
);

    clock_set_pkg::datetime_u datetime;

    logic left_pulse;
    logic right_pulse;
    logic up_pulse;
    logic down_pulse;

    button_hold u_hold_lr (
        .clk          (clk),
        .arst_n       (arst_n),
        .set_en       (set_en),
        .first_btn    (btn_left),
        .second_btn   (btn_right),
        .first_pulse  (left_pulse),
        .second_pulse (right_pulse)
    );

    button_hold u_hold_ud (
        .clk          (clk),
        .arst_n       (arst_n),
        .set_en       (set_en),
        .first_btn    (btn_up),
        .second_btn   (btn_down),
        .first_pulse  (up_pulse),
        .second_pulse (down_pulse)
    );

    cursor_ctrl u_cursor (
        .clk         (clk),
        .arst_n      (arst_n),
        .left_pulse  (left_pulse),
        .right_pulse (right_pulse),
        .cursor      (cursor)
    );

    digit_editor u_editor (
        .clk        (clk),
        .arst_n     (arst_n),
        .up_pulse   (up_pulse),
        .down_pulse (down_pulse),
        .cursor     (cursor),
        .datetime   (datetime)
    );

    weekday_calc u_weekday (
        .clk      (clk),
        .arst_n   (arst_n),
        .datetime (datetime),
        .week     (week)
    );

    assign year   = {datetime.digits.year_th, datetime.digits.year_h,
                     datetime.digits.year_t, datetime.digits.year_u};
    assign month  = {datetime.digits.month_t, datetime.digits.month_u};
    assign day    = {datetime.digits.day_t, datetime.digits.day_u};
    assign hour   = {datetime.digits.hour_t, datetime.digits.hour_u};
    assign minute = {datetime.digits.min_t, datetime.digits.min_u};
    assign second = {datetime.digits.sec_t, datetime.digits.sec_u};

endmodule

`default_nettype wire

//--- testbench/tb_clock_set_model.svh
`ifndef TB_CLOCK_SET_MODEL_SVH
`define TB_CLOCK_SET_MODEL_SVH

// bcd digit n of the date word, n = 0 is second units
function automatic integer digit_at(input logic [55:0] dt, input integer n);
    digit_at = 32'(dt[n*4 +: 4]);
endfunction

function automatic integer year_of(input logic [55:0] dt);
    year_of = 1000 * digit_at(dt, 13) + 100 * digit_at(dt, 12)
            + 10 * digit_at(dt, 11) + digit_at(dt, 10);
endfunction

function automatic integer month_of(input logic [55:0] dt);
    month_of = 10 * digit_at(dt, 9) + digit_at(dt, 8);
endfunction

// returns {max, min} of digit n for the current date
function automatic logic [7:0] digit_range(input logic [55:0] dt, input integer n);
    integer lo;
    integer hi;
    integer mon;
    integer yr;
    lo  = 0;
    hi  = 9;
    mon = month_of(dt);
    yr  = year_of(dt);
    case (n)
        1, 3: hi = 5;
        4: hi = (digit_at(dt, 5) == 2) ? 3 : 9;
        5: hi = 2;
        6: begin
            if (digit_at(dt, 7) == 0) begin
                lo = 1;
            end else if (digit_at(dt, 7) == 3) begin
                hi = (mon inside {1, 3, 5, 7, 8, 10, 12}) ? 1 : 0;
            end else if (digit_at(dt, 7) == 2 && mon == 2) begin
                hi = ((yr % 400 == 0) || (yr % 4 == 0 && yr % 100 != 0)) ? 9 : 8;
            end
        end
        7: hi = (mon == 2) ? 2 : 3;
        8: begin
            if (digit_at(dt, 9) == 1) hi = 2;
            else lo = 1;
        end
        9: hi = 1;
        10: lo = (yr < 10) ? 1 : 0;         // no year 0000 from the units digit
        default: ;
    endcase
    digit_range = {4'(hi), 4'(lo)};
endfunction

function automatic logic [55:0] step_digit(input logic [55:0] dt, input integer n,
                                           input bit up);
    logic [7:0]  rng;
    logic [55:0] res;
    integer      v;
    rng = digit_range(dt, n);
    v   = digit_at(dt, n);
    if (up) v = (v >= 32'(rng[7:4])) ? 32'(rng[3:0]) : v + 1;
    else v = (v <= 32'(rng[3:0])) ? 32'(rng[7:4]) : v - 1;
    res = dt;
    res[n*4 +: 4] = 4'(v);
    step_digit = res;
endfunction

function automatic logic [3:0] weekday_of(input logic [55:0] dt);
    integer      d;
    integer      m;
    integer      y;
    integer      w;
    logic [13:0] y14;
    d   = 10 * digit_at(dt, 7) + digit_at(dt, 6);
    m   = month_of(dt);
    y14 = 14'(year_of(dt));
    if (m == 1 || m == 2) begin
        m   = m + 12;
        y14 = y14 - 14'd1;                  // year 0000 wraps, the year is 14 bits wide
    end
    y = 32'(y14);
    w = (d + 2 * m + (3 * (m + 1)) / 5 + y + y / 4 - y / 100 + y / 400 + 1) % 7;
    weekday_of = (w == 0) ? 4'd7 : 4'(w);
endfunction

function automatic logic [`CS_CURSOR_W-1:0] next_cursor(input logic [`CS_CURSOR_W-1:0] cur,
                                                       input bit left);
    integer c;
    c = 32'(cur);
    if (left) c = (c == `CS_NUM_DIGITS - 1) ? 0 : c + 1;
    else c = (c == 0) ? `CS_NUM_DIGITS - 1 : c - 1;
    next_cursor = `CS_CURSOR_W'(c);
endfunction

`endif

//--- testbench/tb_clock_set.sv
`timescale 1ns/1ps
`default_nettype none

`include "clock_set_params.svh"

module tb_clock_set;

    localparam integer MAX_CYCLES  = 20000;
    localparam integer NUM_PRESSES = 400;

    logic                    clk;
    logic                    arst_n;
    logic                    set_en;
    logic                    btn_left;
    logic                    btn_right;
    logic                    btn_up;
    logic                    btn_down;
    logic [15:0]             year;
    logic [7:0]              month;
    logic [7:0]              day;
    logic [7:0]              hour;
    logic [7:0]              minute;
    logic [7:0]              second;
    logic [3:0]              week;
    logic [`CS_CURSOR_W-1:0] cursor;

    logic [55:0]             exp_dt;
    logic [`CS_CURSOR_W-1:0] exp_cursor;
    integer                  seed;
    integer                  press_idx;
    string                   test_name;

    `include "tb_clock_set_model.svh"

    clock_set_top i_dut (.*);

    always #2 clk = ~clk;

    task automatic wait_cycles(input integer n);
        integer i;
        for (i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic check_value(input string field, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual == expected) else begin
            $display("error: %s %s expected %0h actual %0h", test_name, field, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic compare_outputs;
        check_value("year", 64'(exp_dt[55:40]), 64'(year));
        check_value("month", 64'(exp_dt[39:32]), 64'(month));
        check_value("day", 64'(exp_dt[31:24]), 64'(day));
        check_value("hour", 64'(exp_dt[23:16]), 64'(hour));
        check_value("minute", 64'(exp_dt[15:8]), 64'(minute));
        check_value("second", 64'(exp_dt[7:0]), 64'(second));
        check_value("cursor", 64'(exp_cursor), 64'(cursor));
        check_value("week", 64'(weekday_of(exp_dt)), 64'(week));
    endtask

    task automatic drive_buttons(input logic l, input logic r, input logic u, input logic d);
        btn_left  = l;
        btn_right = r;
        btn_up    = u;
        btn_down  = d;
    endtask

    // one press of random kind and length, then release and settle
    task automatic do_press;
        integer kind;
        integer len;
        integer pick;
        kind = ($random(seed) & 32'h7fff_ffff) % 9;
        len  = `CS_HOLD_CYCLES + 1 + ($random(seed) & 32'h7fff_ffff) % 6;
        pick = ($random(seed) & 32'h7fff_ffff) % 4;
        case (kind)
            0, 1: begin
                test_name = (kind == 0) ? "cursor left" : "cursor right";
                drive_buttons(kind == 0, kind == 1, 1'b0, 1'b0);
                exp_cursor = next_cursor(exp_cursor, kind == 0);
            end
            2, 3, 4, 5: begin
                test_name = (kind < 4) ? "digit up" : "digit down";
                drive_buttons(1'b0, 1'b0, kind < 4, kind >= 4);
                exp_dt = step_digit(exp_dt, 32'(exp_cursor), kind < 4);
            end
            6: begin
                test_name = "pair priority";
                if (pick[0]) begin
                    drive_buttons(1'b1, 1'b1, 1'b0, 1'b0);
                    exp_cursor = next_cursor(exp_cursor, 1'b1);
                end else begin
                    drive_buttons(1'b0, 1'b0, 1'b1, 1'b1);
                    exp_dt = step_digit(exp_dt, 32'(exp_cursor), 1'b1);
                end
            end
            7: begin
                test_name = "short press";
                len = 1 + ($random(seed) & 32'h7fff_ffff) % (`CS_HOLD_CYCLES - 1);
                drive_buttons(pick == 0, pick == 1, pick == 2, pick == 3);
            end
            default: begin
                test_name = "set_en low";
                set_en = 1'b0;                  // held long but outside set mode
                drive_buttons(pick == 0, pick == 1, pick == 2, pick == 3);
            end
        endcase
        wait_cycles(len);
        drive_buttons(1'b0, 1'b0, 1'b0, 1'b0);
        set_en = 1'b1;
        wait_cycles(3);
    endtask

    initial begin
        seed   = 5196;
        clk    = 1'b0;
        arst_n = 1'b0;
        set_en = 1'b0;
        drive_buttons(1'b0, 1'b0, 1'b0, 1'b0);
        test_name  = "reset";
        exp_dt     = `CS_RESET_DATETIME;
        exp_cursor = `CS_CURSOR_W'(`CS_NUM_DIGITS - 1);
        wait_cycles(10);
        arst_n = 1'b1;
        set_en = 1'b1;
        wait_cycles(2);
        compare_outputs();
        for (press_idx = 0; press_idx < NUM_PRESSES; press_idx++) begin
            do_press();
            compare_outputs();
        end
        $display("All tests passed!");
        $finish;
    end

    initial begin : watchdog
        integer n;
        for (n = 0; n < MAX_CYCLES; n++) begin
            @(posedge clk);
        end
        $display("error: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failures found");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+verilog
+incdir+testbench
verilog/clock_set_pkg.sv
verilog/button_hold.sv
verilog/cursor_ctrl.sv
verilog/digit_editor.sv
verilog/weekday_calc.sv
verilog/clock_set_top.sv
testbench/tb_clock_set.sv

//--- run.sh
#!/bin/sh
# builds the clock setting testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_clock_set -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_clock_set
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
